// ==== rtl/floor_logic_pkg.sv ====
// Floor logic package
// Floor count, field widths and car state codes shared by the floor request
// controller and its testbench

package floor_logic_pkg;

    ////////////////////
    // Floors
    ////////////////////

    // Served floors, floor 1 is coded 0
    localparam int NUM_FLOORS = 11;

    // Width of a floor number
    localparam int FLOOR_W = 4;

    // Highest floor code, used as the upper search bound
    localparam logic [FLOOR_W-1:0] TOP_FLOOR = 4'd10;

    ////////////////////
    // Car state
    ////////////////////

    // Width of the state code from the car state machine
    localparam int STATE_W = 6;

    // Codes 0 to 10 mean stopped at floors 1 to 11
    // Anything above is travelling between floors or emergency
    localparam logic [STATE_W-1:0] LAST_STOP_STATE = 6'd10;

endpackage

// ==== rtl/call_registry.sv ====
// Call registry
// Stores hall up, hall down and in-car panel requests per floor.
// Presses set requests, a stop at a floor clears that floor, and
// power-off clears everything. The button lights show the stored requests.

`timescale 1ns/10ps

module call_registry
    import floor_logic_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  power_switch,

    // Button levels, sampled every clock
    input  logic [NUM_FLOORS-1:0] call_buttons,
    input  logic [NUM_FLOORS-1:0] panel_buttons,

    // Car position and stop indication
    input  logic [FLOOR_W-1:0]    current_floor,
    input  logic                  car_stopped,

    // Stored requests toward the planner
    output logic [NUM_FLOORS-1:0] up_requests,
    output logic [NUM_FLOORS-1:0] down_requests,
    output logic [NUM_FLOORS-1:0] panel_requests,

    // Button lights
    output logic [NUM_FLOORS-1:0] call_lights,
    output logic [NUM_FLOORS-1:0] panel_lights
);

    ////////////////////
    // Request masks
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            up_requests    <= '0;
            down_requests  <= '0;
            panel_requests <= '0;
        end else if (!power_switch) begin
            // Power-off drops every pending request
            up_requests    <= '0;
            down_requests  <= '0;
            panel_requests <= '0;
        end else begin
            for (int f = 0; f < NUM_FLOORS; f++) begin
                if (car_stopped && (FLOOR_W'(f) == current_floor)) begin
                    // Car stands here, so serve the floor
                    // A press in the same cycle loses to this clear
                    up_requests[f]    <= 1'b0;
                    down_requests[f]  <= 1'b0;
                    panel_requests[f] <= 1'b0;
                end else begin
                    // Hall call direction follows the caller's position
                    if (call_buttons[f] && (FLOOR_W'(f) > current_floor)) begin
                        up_requests[f] <= 1'b1;
                    end
                    if (call_buttons[f] && (FLOOR_W'(f) < current_floor)) begin
                        down_requests[f] <= 1'b1;
                    end

                    // Panel presses for the current floor are ignored
                    if (panel_buttons[f] && (FLOOR_W'(f) != current_floor)) begin
                        panel_requests[f] <= 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Lights
    ////////////////////

    // A hall light is on while either direction is pending at that floor
    assign call_lights  = up_requests | down_requests;
    assign panel_lights = panel_requests;

endmodule

// ==== rtl/dispatch_planner.sv ====
// Dispatch planner
// Decodes the stopped state of the car, picks the next target floor and
// direction from the stored requests, and gates the door buttons.
// Purely combinational.

`timescale 1ns/10ps

module dispatch_planner
    import floor_logic_pkg::*;
(
    // Car state machine status
    input  logic [STATE_W-1:0]    car_state,
    input  logic [FLOOR_W-1:0]    current_floor,
    input  logic                  car_direction,

    // Operator inputs
    input  logic                  power_switch,
    input  logic                  emergency_btn,
    input  logic                  door_open_btn,
    input  logic                  door_close_btn,

    // Stored requests from the registry
    input  logic [NUM_FLOORS-1:0] up_requests,
    input  logic [NUM_FLOORS-1:0] down_requests,
    input  logic [NUM_FLOORS-1:0] panel_requests,

    // Stop indication back to the registry
    output logic                  car_stopped,

    // Commands toward the car state machine
    output logic [FLOOR_W-1:0]    target_floor,
    output logic                  direction_select,
    output logic                  activate_car,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed
);

    ////////////////////
    // Search helpers
    ////////////////////

    // Result is {found, floor}
    // Walking down from the top leaves the lowest hit above the start floor
    function automatic logic [FLOOR_W:0] nearest_above(
        input logic [NUM_FLOORS-1:0] mask,
        input logic [FLOOR_W-1:0]    from
    );
        logic [FLOOR_W:0] hit;
        hit = '0;
        for (int f = int'(TOP_FLOOR); f >= 0; f--) begin
            if (mask[f] && (FLOOR_W'(f) > from)) begin
                hit = {1'b1, FLOOR_W'(f)};
            end
        end
        return hit;
    endfunction

    // Walking up from the bottom leaves the highest hit below the start floor
    function automatic logic [FLOOR_W:0] nearest_below(
        input logic [NUM_FLOORS-1:0] mask,
        input logic [FLOOR_W-1:0]    from
    );
        logic [FLOOR_W:0] hit;
        hit = '0;
        for (int f = 0; f <= int'(TOP_FLOOR); f++) begin
            if (mask[f] && (FLOOR_W'(f) < from)) begin
                hit = {1'b1, FLOOR_W'(f)};
            end
        end
        return hit;
    endfunction

    ////////////////////
    // Stop decode
    ////////////////////

    logic                  search_en;
    logic [NUM_FLOORS-1:0] all_requests;

    assign car_stopped  = (car_state <= LAST_STOP_STATE);
    assign search_en    = car_stopped && power_switch && !emergency_btn;
    assign all_requests = up_requests | down_requests | panel_requests;

    ////////////////////
    // Candidate floors
    ////////////////////

    logic [FLOOR_W:0] panel_up;
    logic [FLOOR_W:0] panel_down;
    logic [FLOOR_W:0] hall_up;
    logic [FLOOR_W:0] hall_down;
    logic [FLOOR_W:0] any_up;
    logic [FLOOR_W:0] any_down;
    logic [FLOOR_W:0] pick;

    // The strict compares inside the helpers skip the current floor
    assign panel_up   = nearest_above(panel_requests, current_floor);
    assign panel_down = nearest_below(panel_requests, current_floor);
    assign hall_up    = nearest_above(up_requests, current_floor);
    assign hall_down  = nearest_below(down_requests, current_floor);
    assign any_up     = nearest_above(all_requests, current_floor);
    assign any_down   = nearest_below(all_requests, current_floor);

    ////////////////////
    // Priority select
    ////////////////////

    always_comb begin
        // Panel requests first, same direction before the reverse one
        if (car_direction) begin
            pick = panel_up[FLOOR_W] ? panel_up : panel_down;
        end else begin
            pick = panel_down[FLOOR_W] ? panel_down : panel_up;
        end

        // Then hall calls that match the travel direction
        if (!pick[FLOOR_W]) begin
            pick = car_direction ? hall_up : hall_down;
        end

        // Then anything at all, upward first
        if (!pick[FLOOR_W]) begin
            pick = any_up[FLOOR_W] ? any_up : any_down;
        end

        // No dispatch while moving, powered off or in emergency
        if (!search_en) begin
            pick = '0;
        end
    end

    assign activate_car = pick[FLOOR_W];

    // Idle car keeps its floor and direction
    assign target_floor     = pick[FLOOR_W] ? pick[FLOOR_W-1:0] : current_floor;
    assign direction_select = pick[FLOOR_W] ? (pick[FLOOR_W-1:0] > current_floor)
                                            : car_direction;

    ////////////////////
    // Door permission
    ////////////////////

    // Door buttons only count while standing at a floor with power on
    assign door_open_allowed  = car_stopped && power_switch && door_open_btn;
    assign door_close_allowed = car_stopped && power_switch && door_close_btn;

endmodule

// ==== rtl/floor_logic_top.sv ====
// Floor request controller
// Sits beside the car state machine for an eleven-floor elevator.
// Joins the request registry and the dispatch planner.

`timescale 1ns/10ps

module floor_logic_top
    import floor_logic_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset_n,

    // Buttons
    input  logic [NUM_FLOORS-1:0] call_buttons,
    input  logic [NUM_FLOORS-1:0] panel_buttons,
    input  logic                  door_open_btn,
    input  logic                  door_close_btn,
    input  logic                  emergency_btn,
    input  logic                  power_switch,

    // Car state machine status
    input  logic [FLOOR_W-1:0]    current_floor,
    input  logic [STATE_W-1:0]    car_state,
    input  logic                  car_direction,

    // Commands toward the car state machine
    output logic [FLOOR_W-1:0]    target_floor,
    output logic                  direction_select,
    output logic                  activate_car,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed,

    // Button lights
    output logic [NUM_FLOORS-1:0] call_lights,
    output logic [NUM_FLOORS-1:0] panel_lights
);

    logic [NUM_FLOORS-1:0] up_requests;
    logic [NUM_FLOORS-1:0] down_requests;
    logic [NUM_FLOORS-1:0] panel_requests;
    logic                  car_stopped;

    ////////////////////
    // Request store
    ////////////////////

    call_registry i_call_registry (
        .clock          (clock),
        .reset_n        (reset_n),
        .power_switch   (power_switch),
        .call_buttons   (call_buttons),
        .panel_buttons  (panel_buttons),
        .current_floor  (current_floor),
        .car_stopped    (car_stopped),
        .up_requests    (up_requests),
        .down_requests  (down_requests),
        .panel_requests (panel_requests),
        .call_lights    (call_lights),
        .panel_lights   (panel_lights)
    );

    ////////////////////
    // Planner
    ////////////////////

    dispatch_planner i_dispatch_planner (
        .car_state          (car_state),
        .current_floor      (current_floor),
        .car_direction      (car_direction),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .up_requests        (up_requests),
        .down_requests      (down_requests),
        .panel_requests     (panel_requests),
        .car_stopped        (car_stopped),
        .target_floor       (target_floor),
        .direction_select   (direction_select),
        .activate_car       (activate_car),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// ==== tb/floor_logic_sva.sv ====
// Floor controller assertions
// Bound into the top level, checks dispatch gating, door gating and
// power-off clearing of the lights

`timescale 1ns/10ps

module floor_logic_sva
    import floor_logic_pkg::*;
(
    input logic                  clock,
    input logic                  reset_n,
    input logic                  power_switch,
    input logic                  emergency_btn,
    input logic [STATE_W-1:0]    car_state,
    input logic                  activate_car,
    input logic                  door_open_allowed,
    input logic                  door_close_allowed,
    input logic [NUM_FLOORS-1:0] call_lights,
    input logic [NUM_FLOORS-1:0] panel_lights
);

    // Dispatch only while powered, calm and standing at a floor
    activate_gated: assert property (@(posedge clock) disable iff (!reset_n)
        activate_car |-> (power_switch && !emergency_btn && car_state <= LAST_STOP_STATE))
        else $error("activate_car high outside a powered stop");

    // Doors stay shut between floors
    doors_shut_moving: assert property (@(posedge clock) disable iff (!reset_n)
        (car_state > LAST_STOP_STATE) |-> (!door_open_allowed && !door_close_allowed))
        else $error("door output high while the car is moving");

    power_off_dark: assert property (@(posedge clock) disable iff (!reset_n)
        !power_switch |=> (call_lights == '0 && panel_lights == '0))
        else $error("lights still on one clock after power-off");

endmodule

bind floor_logic_top floor_logic_sva i_floor_logic_sva (
    .clock              (clock),
    .reset_n            (reset_n),
    .power_switch       (power_switch),
    .emergency_btn      (emergency_btn),
    .car_state          (car_state),
    .activate_car       (activate_car),
    .door_open_allowed  (door_open_allowed),
    .door_close_allowed (door_close_allowed),
    .call_lights        (call_lights),
    .panel_lights       (panel_lights)
);

// ==== tb/floor_logic_tb.sv ====
// Floor request controller testbench
// Drives directed and random button traffic into the controller, keeps a
// reference model of the request masks and compares every output each cycle

`timescale 1ns/10ps

module floor_logic_tb
    import floor_logic_pkg::*;
();

    localparam int RUN_LIMIT_NS = 100000;
    localparam int RANDOM_CYCLES = 3000;

    logic                  clock;
    logic                  reset_n;
    logic [NUM_FLOORS-1:0] call_buttons;
    logic [NUM_FLOORS-1:0] panel_buttons;
    logic                  door_open_btn;
    logic                  door_close_btn;
    logic                  emergency_btn;
    logic                  power_switch;
    logic [FLOOR_W-1:0]    current_floor;
    logic [STATE_W-1:0]    car_state;
    logic                  car_direction;
    logic [FLOOR_W-1:0]    target_floor;
    logic                  direction_select;
    logic                  activate_car;
    logic                  door_open_allowed;
    logic                  door_close_allowed;
    logic [NUM_FLOORS-1:0] call_lights;
    logic [NUM_FLOORS-1:0] panel_lights;

    // Reference request masks and bookkeeping
    logic [NUM_FLOORS-1:0] up_model;
    logic [NUM_FLOORS-1:0] down_model;
    logic [NUM_FLOORS-1:0] panel_model;
    logic [NUM_FLOORS-1:0] served;
    logic [31:0]           rng;
    int                    dispatches;

    floor_logic_top i_floor_logic_top (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(RUN_LIMIT_NS);
        fail_run("Simulation ran past its time limit");
    end

    ////////////////////
    // Reporting
    ////////////////////

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic fail_run(input string why);
        $display("Failure at %0t ns: %s", $time, why);
        abort_run();
    endtask

    task automatic check_floor(input string name, input logic [FLOOR_W-1:0] got,
                               input logic [FLOOR_W-1:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input logic [NUM_FLOORS-1:0] got,
                              input logic [NUM_FLOORS-1:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, want);
            abort_run();
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Floors below (rel < 0), at (rel == 0) or above (rel > 0) the car
    function automatic logic [NUM_FLOORS-1:0] floors_where(input logic [FLOOR_W-1:0] cur,
                                                           input int rel);
        logic [NUM_FLOORS-1:0] m;
        m = '0;
        for (int f = 0; f < NUM_FLOORS; f++) begin
            if ((rel > 0 && f > int'(cur)) || (rel < 0 && f < int'(cur)) ||
                (rel == 0 && f == int'(cur))) begin
                m[FLOOR_W'(f)] = 1'b1;
            end
        end
        return m;
    endfunction

    // Walk outward one floor at a time and give -1 when nothing is pending that way
    function automatic int nearest_request(input logic [NUM_FLOORS-1:0] mask,
                                           input logic [FLOOR_W-1:0] cur, input logic upward);
        int f;
        int hit;
        hit = -1;
        for (int d = 1; d < NUM_FLOORS; d++) begin
            f = upward ? int'(cur) + d : int'(cur) - d;
            if (hit < 0 && f >= 0 && f < NUM_FLOORS) begin
                if (mask[FLOOR_W'(f)]) begin
                    hit = f;
                end
            end
        end
        return hit;
    endfunction

    // Expected {activate_car, direction_select, target_floor}
    function automatic logic [FLOOR_W+1:0] plan_ref(
        input logic [NUM_FLOORS-1:0] up, input logic [NUM_FLOORS-1:0] down,
        input logic [NUM_FLOORS-1:0] panel, input logic [FLOOR_W-1:0] cur,
        input logic dir, input logic [STATE_W-1:0] state, input logic power,
        input logic emergency);
        int                    t;
        logic [NUM_FLOORS-1:0] all_mask;
        t = -1;
        all_mask = up | down | panel;
        if (state <= LAST_STOP_STATE && power && !emergency) begin
            t = nearest_request(panel, cur, dir);
            if (t < 0) t = nearest_request(panel, cur, !dir);
            if (t < 0) t = dir ? nearest_request(up, cur, 1'b1) : nearest_request(down, cur, 1'b0);
            if (t < 0) t = nearest_request(all_mask, cur, 1'b1);
            if (t < 0) t = nearest_request(all_mask, cur, 1'b0);
        end
        if (t < 0) begin
            return {1'b0, dir, cur};
        end else begin
            return {1'b1, (t > int'(cur)), FLOOR_W'(t)};
        end
    endfunction

    assign served = (car_state <= LAST_STOP_STATE) ? floors_where(current_floor, 0) : '0;

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n || !power_switch) begin
            up_model    <= '0;
            down_model  <= '0;
            panel_model <= '0;
        end else begin
            up_model    <= (up_model | (call_buttons & floors_where(current_floor, 1))) & ~served;
            down_model  <= (down_model | (call_buttons & floors_where(current_floor, -1))) & ~served;
            panel_model <= (panel_model | (panel_buttons & ~floors_where(current_floor, 0)))
                           & ~served;
        end
    end

    ////////////////////
    // Compare
    ////////////////////

    task automatic compare_outputs();
        logic [FLOOR_W+1:0] want;
        logic               stopped;
        want = plan_ref(up_model, down_model, panel_model, current_floor, car_direction,
                        car_state, power_switch, emergency_btn);
        stopped = (car_state <= LAST_STOP_STATE);
        check_mask("call_lights", call_lights, up_model | down_model);
        check_mask("panel_lights", panel_lights, panel_model);
        check_bit("activate_car", activate_car, want[FLOOR_W+1]);
        check_bit("direction_select", direction_select, want[FLOOR_W]);
        check_floor("target_floor", target_floor, want[FLOOR_W-1:0]);
        check_bit("door_open_allowed", door_open_allowed, stopped && power_switch && door_open_btn);
        check_bit("door_close_allowed", door_close_allowed,
                  stopped && power_switch && door_close_btn);
        if (want[FLOOR_W+1]) dispatches++;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clock) begin
        if (reset_n) compare_outputs();
    end

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    task automatic drive_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        next_rand(a);
        power_switch   = (a[4:0] != 5'd0);
        emergency_btn  = (a[7:5] == 3'd0);
        car_direction  = a[8];
        door_open_btn  = a[9];
        door_close_btn = a[10];
        current_floor  = FLOOR_W'((a >> 11) % (int'(TOP_FLOOR) + 1));
        next_rand(a);
        if (a[0]) car_state = STATE_W'((a >> 1) % (int'(LAST_STOP_STATE) + 1));
        else car_state = STATE_W'(int'(LAST_STOP_STATE) + 1 + int'((a >> 1) % 53));
        // Three draws ANDed keep presses sparse
        next_rand(a);
        next_rand(b);
        next_rand(c);
        call_buttons = NUM_FLOORS'(a & b & c);
        next_rand(a);
        next_rand(b);
        next_rand(c);
        panel_buttons = NUM_FLOORS'(a & b & c);
    endtask

    task automatic wait_for_dark(input int limit);
        int n;
        n = 0;
        @(negedge clock);
        while (call_lights != '0 || panel_lights != '0) begin
            if (n >= limit) fail_run("Lights still on after power-off");
            n++;
            @(negedge clock);
        end
    endtask

    initial begin
        rng            = 32'h7688_21bc;
        dispatches     = 0;
        reset_n        = 1'b0;
        power_switch   = 1'b1;
        emergency_btn  = 1'b0;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        call_buttons   = '0;
        panel_buttons  = '0;
        current_floor  = '0;
        car_state      = 6'd20;
        car_direction  = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        reset_n = 1'b1;

        @(negedge clock);
        check_mask("call_lights", call_lights, '0);
        check_mask("panel_lights", panel_lights, '0);
        check_bit("activate_car", activate_car, 1'b0);

        // Presses while travelling past floor 6
        // The press at floor 6 itself is ignored
        @(posedge clock);
        #1;
        current_floor = 4'd5;
        call_buttons  = 11'h124;
        panel_buttons = 11'h220;
        @(posedge clock);
        #1;
        call_buttons  = '0;
        panel_buttons = '0;
        @(negedge clock);
        check_mask("call_lights", call_lights, 11'h104);
        check_mask("panel_lights", panel_lights, 11'h200);
        check_bit("activate_car", activate_car, 1'b0);

        // Emergency at floor 6 holds the car while requests stay
        @(posedge clock);
        #1;
        car_state     = 6'd5;
        car_direction = 1'b0;
        emergency_btn = 1'b1;
        @(negedge clock);
        check_bit("activate_car", activate_car, 1'b0);
        check_mask("call_lights", call_lights, 11'h104);
        @(posedge clock);
        #1;
        emergency_btn = 1'b0;
        // Panel request wins and reverses the direction
        @(negedge clock);
        check_bit("activate_car", activate_car, 1'b1);
        check_floor("target_floor", target_floor, 4'd9);
        check_bit("direction_select", direction_select, 1'b1);

        // Stop at floor 9
        @(posedge clock);
        #1;
        current_floor = 4'd8;
        car_state     = 6'd8;
        @(posedge clock);
        #1;
        car_state = 6'd20;
        @(negedge clock);
        check_mask("call_lights", call_lights, 11'h004);
        check_mask("panel_lights", panel_lights, 11'h200);

        @(posedge clock);
        #1;
        power_switch = 1'b0;
        wait_for_dark(4);
        @(posedge clock);
        #1;
        power_switch = 1'b1;

        // Door gating
        @(posedge clock);
        #1;
        door_open_btn  = 1'b1;
        door_close_btn = 1'b1;
        @(negedge clock);
        check_bit("door_open_allowed", door_open_allowed, 1'b0);
        check_bit("door_close_allowed", door_close_allowed, 1'b0);
        @(posedge clock);
        #1;
        car_state     = 6'd3;
        current_floor = 4'd3;
        @(negedge clock);
        check_bit("door_open_allowed", door_open_allowed, 1'b1);
        check_bit("door_close_allowed", door_close_allowed, 1'b1);
        @(posedge clock);
        #1;
        power_switch = 1'b0;
        @(negedge clock);
        check_bit("door_open_allowed", door_open_allowed, 1'b0);
        check_bit("door_close_allowed", door_close_allowed, 1'b0);

        // Count only the dispatches that the random traffic calls for
        dispatches = 0;
        repeat (RANDOM_CYCLES) begin
            @(posedge clock);
            #1;
            drive_random();
        end
        @(negedge clock);

        if (dispatches == 0) begin
            fail_run("Random traffic never activated the car");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== all.f ====
rtl/floor_logic_pkg.sv
rtl/call_registry.sv
rtl/dispatch_planner.sv
rtl/floor_logic_top.sv
tb/floor_logic_sva.sv
tb/floor_logic_tb.sv

// ==== Makefile ====
# Verilator build and run for the floor request controller

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := floor_logic_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
